//--- Bender.yml
package:
  name: memsystem

sources:
  - memSysPkg.sv
  - cacheWay.sv
  - waySelect.sv
  - bankedMemory.sv
  - cacheController.sv
  - memSystem.sv
  - target: test
    files:
      - memSystemTb.sv

//--- bankedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module bankedMemory
   import memSysPkg::*;
#(
   parameter int bankLatency = 2
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  memReqT                 req,
   output logic                   memStall,
   output logic                   rdValid,
   output logic [wordWidth-1:0]   rdData,
   output logic [wordSelBits-1:0] rdBank
);

   localparam int memWords = 2 ** memAddrWidth;
   localparam int cntBits = $clog2(bankLatency + 1);

   logic [wordWidth-1:0] memArr [memWords];
   logic [cntBits-1:0] busyCnt [wordsPerLine];
   logic [wordSelBits-1:0] reqBank;
   logic taken;

   // read return pipeline, stage 0 loads at the taking edge
   logic [bankLatency-1:0] pipeValid;
   logic [wordSelBits-1:0] pipeBank [bankLatency];
   logic [wordWidth-1:0] pipeData [bankLatency];

   // low word address bits pick the bank
   assign reqBank = req.addr[wordSelBits-1:0];
   assign memStall = (req.rd | req.wr) & (busyCnt[reqBank] != '0);
   assign taken = (req.rd | req.wr) & ~memStall;

   // ##########################################################
   // bank busy counters
   // ##########################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < wordsPerLine; b++) begin
            busyCnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < wordsPerLine; b++) begin
            if (taken && reqBank == wordSelBits'(b)) begin
               busyCnt[b] <= cntBits'(bankLatency);
            end else if (busyCnt[b] != '0) begin
               busyCnt[b] <= busyCnt[b] - 1'b1;
            end
         end
      end
   end

   // writes complete at the taking edge
   always_ff @(posedge clk) begin
      if (taken && req.wr) begin
         memArr[req.addr] <= req.data;
      end
   end

   // ##########################################################
   // read returns
   // ##########################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         pipeValid <= '0;
      end else begin
         pipeValid[0] <= taken & req.rd;
         for (int s = 1; s < bankLatency; s++) begin
            pipeValid[s] <= pipeValid[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipeBank[0] <= reqBank;
      pipeData[0] <= memArr[req.addr];
      for (int s = 1; s < bankLatency; s++) begin
         pipeBank[s] <= pipeBank[s-1];
         pipeData[s] <= pipeData[s-1];
      end
   end

   assign rdValid = pipeValid[bankLatency-1];
   assign rdData = pipeData[bankLatency-1];
   assign rdBank = pipeBank[bankLatency-1];

   // controller never reads and writes in one request
   oneOp: assert property (
      @(posedge clk) disable iff (rst)
      !(req.rd && req.wr)
   ) else $error("read and write requested together");

endmodule

`default_nettype wire

//--- cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController
   import memSysPkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rd,
   input  logic                   wr,
   input  logic [addrWidth-1:0]   addr,
   input  logic [wordWidth-1:0]   dataIn,
   input  logic                   anyHit,
   input  logic                   targetDirty,
   input  logic                   targetValid,
   input  logic [tagBits-1:0]     targetTag,
   input  logic                   memStall,
   input  logic                   rdValid,
   input  logic [wordWidth-1:0]   rdData,
   input  logic [wordSelBits-1:0] rdBank,
   output wayCmdT                 wayCmd,
   output logic                   wayWrite,
   output logic                   lockWay,
   output logic                   accessDone,
   output memReqT                 memReq,
   output logic                   done,
   output logic                   stall,
   output logic                   cacheHit
);

   ctrlStateT state;
   ctrlStateT nextState;
   cacheReqT req;
   // top bit marks all four words issued
   logic [wordSelBits:0] issueCnt;
   logic [wordSelBits-1:0] fillCnt;
   logic accept;
   logic issueTaken;

   // new request allowed in idle and in both done states
   assign accept = (state == stIdle || state == stDone || state == stFillDone) && (rd || wr);
   assign issueTaken = (memReq.rd || memReq.wr) && !memStall;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= stIdle;
      end else begin
         state <= nextState;
      end
   end

   // latched request, inputs may change afterwards
   always_ff @(posedge clk) begin
      if (accept) begin
         req.addr <= addrFieldsT'(addr);
         req.data <= dataIn;
         req.write <= wr;
      end
   end

   // ##########################################################
   // fill counters
   // ##########################################################
   always_ff @(posedge clk) begin
      if (rst || state == stCompare) begin
         issueCnt <= '0;
         fillCnt <= '0;
      end else if (state == stEvict && issueTaken && issueCnt[wordSelBits-1:0] == '1) begin
         // last write out, refill restarts at word 0
         issueCnt <= '0;
      end else begin
         if (issueTaken) begin
            issueCnt <= issueCnt + 1'b1;
         end
         if (state == stRefill && rdValid) begin
            fillCnt <= fillCnt + 1'b1;
         end
      end
   end

   // ##########################################################
   // next state and outputs
   // ##########################################################
   always_comb begin
      nextState = state;
      // ways see the latched request by default
      wayCmd.enable = (state != stIdle);
      wayCmd.compare = 1'b1;
      wayCmd.tag = req.addr.tag;
      wayCmd.index = req.addr.index;
      wayCmd.word = req.addr.offset[offsetBits-1:1];
      wayCmd.data = req.data;
      wayCmd.validIn = 1'b1;
      wayWrite = 1'b0;
      lockWay = 1'b0;
      accessDone = 1'b0;
      memReq.rd = 1'b0;
      memReq.wr = 1'b0;
      memReq.addr = {req.addr.tag, req.addr.index, issueCnt[wordSelBits-1:0]};
      // evicted word is merged in at the top level
      memReq.data = '0;
      done = 1'b0;
      stall = 1'b1;
      cacheHit = 1'b0;
      case (state)
         stIdle: begin
            stall = 1'b0;
            if (accept) begin
               nextState = stCompare;
            end
         end
         stCompare: begin
            lockWay = 1'b1;
            wayWrite = req.write && anyHit;
            if (anyHit) begin
               nextState = stDone;
            end else if (targetValid && targetDirty) begin
               nextState = stEvict;
            end else begin
               nextState = stRefill;
            end
         end
         stEvict: begin
            // old line goes out under its stored tag
            wayCmd.compare = 1'b0;
            wayCmd.word = issueCnt[wordSelBits-1:0];
            memReq.wr = 1'b1;
            memReq.addr = {targetTag, req.addr.index, issueCnt[wordSelBits-1:0]};
            if (issueTaken && issueCnt[wordSelBits-1:0] == '1) begin
               nextState = stRefill;
            end
         end
         stRefill: begin
            // reads go out back to back, returns land by bank
            wayCmd.compare = 1'b0;
            wayCmd.word = rdBank;
            wayCmd.data = rdData;
            wayWrite = rdValid;
            memReq.rd = !issueCnt[wordSelBits];
            if (rdValid && fillCnt == '1) begin
               nextState = req.write ? stFinalWrite : stFillDone;
            end
         end
         stFinalWrite: begin
            // line is resident now, write it like a hit
            wayWrite = 1'b1;
            nextState = stFillDone;
         end
         stDone, stFillDone: begin
            done = 1'b1;
            stall = 1'b0;
            cacheHit = (state == stDone);
            accessDone = 1'b1;
            nextState = accept ? stCompare : stIdle;
         end
         default: begin
            nextState = stIdle;
         end
      endcase
   end

   doneNotStalled: assert property (
      @(posedge clk) disable iff (rst)
      !(done && stall)
   ) else $error("done raised while stalled");

endmodule

`default_nettype wire

//--- cacheWay.sv
`timescale 1ns/1ps
`default_nettype none

module cacheWay
   import memSysPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  wayCmdT    cmd,
   input  logic      write,
   output wayStatusT status
);

   localparam int numSets = 2 ** indexBits;

   // ##########################################################
   // storage
   // ##########################################################
   logic [tagBits-1:0] tagArr [numSets];
   logic [wordWidth-1:0] dataArr [numSets][wordsPerLine];
   logic [numSets-1:0] validBits;
   logic [numSets-1:0] dirtyBits;

   logic doWrite;
   logic tagMatch;

   assign doWrite = cmd.enable & write;
   assign tagMatch = (tagArr[cmd.index] == cmd.tag);

   // ##########################################################
   // lookup, all combinational on the current command
   // ##########################################################
   // hit only counts in compare mode
   assign status.hit = cmd.enable & cmd.compare & validBits[cmd.index] & tagMatch;
   assign status.valid = validBits[cmd.index];
   assign status.dirty = dirtyBits[cmd.index];
   assign status.tag = tagArr[cmd.index];
   // selected word of the indexed line
   assign status.data = dataArr[cmd.index][cmd.word];

   // valid and dirty per set
   always_ff @(posedge clk) begin
      if (rst) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (doWrite) begin
         if (cmd.compare) begin
            // cpu write into a resident line
            dirtyBits[cmd.index] <= 1'b1;
         end else begin
            // fill from memory, line becomes clean
            validBits[cmd.index] <= cmd.validIn;
            dirtyBits[cmd.index] <= 1'b0;
         end
      end
   end

   // tag follows the fill, data follows every write
   always_ff @(posedge clk) begin
      if (doWrite) begin
         dataArr[cmd.index][cmd.word] <= cmd.data;
         if (!cmd.compare) begin
            tagArr[cmd.index] <= cmd.tag;
         end
      end
   end

   // the controller only writes in compare mode once the line is resident
   writeNeedsHit: assert property (
      @(posedge clk) disable iff (rst)
      (doWrite && cmd.compare) |-> status.hit
   ) else $error("compare write without a hit");

endmodule

`default_nettype wire

//--- memSysPkg.sv
`default_nettype none

package memSysPkg;

   // ##########################################################
   // address and data widths
   // ##########################################################
   localparam int addrWidth = 16;
   localparam int wordWidth = 16;

   // byte address split as tag, index, offset
   localparam int tagBits = 5;
   localparam int indexBits = 8;
   localparam int offsetBits = 3;

   // line words and memory banks share one count
   localparam int wordsPerLine = 4;
   localparam int wordSelBits = $clog2(wordsPerLine);

   // memory is word addressed, offset bit 0 dropped
   localparam int memAddrWidth = addrWidth - 1;

   // ##########################################################
   // bundles
   // ##########################################################
   typedef struct packed {
      logic [tagBits-1:0] tag;
      logic [indexBits-1:0] index;
      logic [offsetBits-1:0] offset;
   } addrFieldsT;

   // request as latched at acceptance
   typedef struct packed {
      addrFieldsT addr;
      logic [wordWidth-1:0] data;
      logic write;
   } cacheReqT;

   // shared command to both ways, write enable steered per way
   typedef struct packed {
      logic enable;
      logic compare;
      logic [tagBits-1:0] tag;
      logic [indexBits-1:0] index;
      logic [wordSelBits-1:0] word;
      logic [wordWidth-1:0] data;
      logic validIn;
   } wayCmdT;

   typedef struct packed {
      logic hit;
      logic valid;
      logic dirty;
      logic [tagBits-1:0] tag;
      logic [wordWidth-1:0] data;
   } wayStatusT;

   typedef struct packed {
      logic rd;
      logic wr;
      logic [memAddrWidth-1:0] addr;
      logic [wordWidth-1:0] data;
   } memReqT;

   typedef enum logic [2:0] {
      stIdle,
      stCompare,
      stEvict,
      stRefill,
      stFinalWrite,
      stDone,
      stFillDone
   } ctrlStateT;

endpackage

`default_nettype wire

//--- memSystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem
   import memSysPkg::*;
#(
   parameter int bankLatency = 2
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 rd,
   input  logic                 wr,
   input  logic [addrWidth-1:0] addr,
   input  logic [wordWidth-1:0] dataIn,
   output logic [wordWidth-1:0] dataOut,
   output logic                 done,
   output logic                 stall,
   output logic                 cacheHit
);

   wayCmdT wayCmd;
   wayStatusT status0;
   wayStatusT status1;
   memReqT ctrlMemReq;
   memReqT memReq;
   logic wayWrite;
   logic lockWay;
   logic accessDone;
   logic write0;
   logic write1;
   logic anyHit;
   logic targetDirty;
   logic targetValid;
   logic [tagBits-1:0] targetTag;
   logic memStall;
   logic rdValid;
   logic [wordWidth-1:0] rdData;
   logic [wordSelBits-1:0] rdBank;

   // memory writes happen only on eviction, the word comes from the selected way
   always_comb begin
      memReq = ctrlMemReq;
      memReq.data = dataOut;
   end

   cacheController ctrl (
      .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .dataIn(dataIn),
      .anyHit(anyHit), .targetDirty(targetDirty), .targetValid(targetValid),
      .targetTag(targetTag), .memStall(memStall), .rdValid(rdValid),
      .rdData(rdData), .rdBank(rdBank), .wayCmd(wayCmd), .wayWrite(wayWrite),
      .lockWay(lockWay), .accessDone(accessDone), .memReq(ctrlMemReq),
      .done(done), .stall(stall), .cacheHit(cacheHit)
   );

   cacheWay way0 (.clk(clk), .rst(rst), .cmd(wayCmd), .write(write0), .status(status0));
   cacheWay way1 (.clk(clk), .rst(rst), .cmd(wayCmd), .write(write1), .status(status1));

   waySelect sel (
      .clk(clk), .rst(rst), .way0(status0), .way1(status1), .wayWrite(wayWrite),
      .lockWay(lockWay), .accessDone(accessDone), .write0(write0), .write1(write1),
      .anyHit(anyHit), .targetDirty(targetDirty), .targetValid(targetValid),
      .targetTag(targetTag), .dataOut(dataOut)
   );

   bankedMemory #(.bankLatency(bankLatency)) mem (
      .clk(clk), .rst(rst), .req(memReq), .memStall(memStall),
      .rdValid(rdValid), .rdData(rdData), .rdBank(rdBank)
   );

endmodule

`default_nettype wire

//--- memSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSystemTb
   import memSysPkg::*;
();

   // ##########################################################
   // limits and record types
   // ##########################################################
   localparam int halfPeriod = 20;
   localparam int driveDelay = 2;
   localparam int sampleDelay = 1;
   localparam int resetCycles = 5;
   localparam int doneLimit = 100;
   localparam int readyLimit = 100;
   localparam int idleLimit = 500;
   localparam int randomOps = 200;

   // expected outcome of one access
   typedef struct packed {
      logic hit;
      logic [wordWidth-1:0] data;
   } expectT;

   // request waiting for its done pulse
   typedef struct packed {
      logic isRead;
      logic [addrWidth-1:0] addr;
      expectT exp;
      logic [31:0] acceptCycle;
   } pendT;

   logic clk;
   logic rst;
   logic rd;
   logic wr;
   logic [addrWidth-1:0] addr;
   logic [wordWidth-1:0] dataIn;
   logic [wordWidth-1:0] dataOut;
   logic done;
   logic stall;
   logic cacheHit;

   // reference cache and memory keyed by word address
   logic [wordWidth-1:0] refMem [logic [addrWidth-2:0]];
   logic [tagBits-1:0] refTag [2**indexBits][2];
   bit refValid [2**indexBits][2];
   bit refRepl;

   pendT pendQ [$];
   int cycleCnt;
   int checkCnt;
   int valueErrs;
   int otherErrs;
   int doneStrobes;
   bit abortRun;
   int unsigned seed;

   memSystem #(.bankLatency(2)) memSystem_inst (
      .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .dataIn(dataIn),
      .dataOut(dataOut), .done(done), .stall(stall), .cacheHit(cacheHit)
   );

   always #halfPeriod clk = ~clk;

   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
   end

   function automatic logic [addrWidth-1:0] makeAddr(input int tag, input int index,
                                                     input int word);
      addrFieldsT f;
      f.tag = tagBits'(tag);
      f.index = indexBits'(index);
      // byte bit 0 unused
      f.offset = {wordSelBits'(word), 1'b0};
      return f;
   endfunction

   // ##########################################################
   // reference model updated once per request in issue order
   // ##########################################################
   function automatic expectT refAccess(input logic isWrite, input logic [addrWidth-1:0] a,
                                        input logic [wordWidth-1:0] d);
      expectT res;
      addrFieldsT f;
      logic [addrWidth-2:0] w;
      int way;
      f = addrFieldsT'(a);
      w = a[addrWidth-1:1];
      res.hit = 1'b0;
      way = 0;
      for (int i = 0; i < 2; i++) begin
         if (refValid[f.index][i] && refTag[f.index][i] == f.tag) begin
            res.hit = 1'b1;
            way = i;
         end
      end
      if (!res.hit) begin
         // empty way first or else the replacement bit
         if (!refValid[f.index][0]) begin
            way = 0;
         end else if (!refValid[f.index][1]) begin
            way = 1;
         end else begin
            way = refRepl;
         end
         refValid[f.index][way] = 1'b1;
         refTag[f.index][way] = f.tag;
      end
      if (isWrite) begin
         refMem[w] = d;
      end
      res.data = refMem.exists(w) ? refMem[w] : '0;
      // flips on every completed access
      refRepl = ~refRepl;
      return res;
   endfunction

   // called and left at drive time
   task automatic waitReady();
      int waitCnt;
      waitCnt = 0;
      while (stall !== 1'b0 && !abortRun && waitCnt < readyLimit) begin
         @(posedge clk);
         #driveDelay;
         waitCnt++;
      end
      if (stall !== 1'b0 && !abortRun) begin
         $display("timeout: stall stayed high for %0d cycles", readyLimit);
         otherErrs++;
         abortRun = 1'b1;
      end
   endtask

   task automatic issueAccess(input logic isWrite, input logic [addrWidth-1:0] a,
                              input logic [wordWidth-1:0] d);
      pendT pend;
      waitReady();
      if (abortRun) begin
         return;
      end
      pend.isRead = ~isWrite;
      pend.addr = a;
      pend.exp = refAccess(isWrite, a, d);
      // cycle counter in the strobe cycle
      pend.acceptCycle = cycleCnt;
      if (done === 1'b1) begin
         doneStrobes++;
      end
      pendQ.push_back(pend);
      rd = ~isWrite;
      wr = isWrite;
      addr = a;
      dataIn = d;
      @(posedge clk);
      #driveDelay;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #driveDelay;
      end
   endtask

   // ##########################################################
   // checker handling one request at a time in issue order
   // ##########################################################
   initial begin : checkDone
      pendT pend;
      int waitCnt;
      bit seenDone;
      while (!abortRun) begin
         waitCnt = 0;
         while (pendQ.size() == 0 && waitCnt < idleLimit) begin
            @(posedge clk);
            #sampleDelay;
            waitCnt++;
         end
         if (pendQ.size() == 0) begin
            $display("no request arrived for %0d cycles", idleLimit);
            otherErrs++;
            abortRun = 1'b1;
         end else begin
            pend = pendQ[0];
            waitCnt = 0;
            seenDone = 1'b0;
            while (!seenDone && waitCnt < doneLimit) begin
               @(posedge clk);
               #sampleDelay;
               waitCnt++;
               seenDone = (done === 1'b1);
               // busy until the done cycle
               if (!seenDone) begin
                  assert (stall === 1'b1) else begin
                     $display("FAILED at %0t: stall low while %h pending", $time, pend.addr);
                     valueErrs++;
                  end
               end
            end
            if (!seenDone) begin
               $display("timeout: no done within %0d cycles for address %h", doneLimit,
                        pend.addr);
               otherErrs++;
               abortRun = 1'b1;
            end else begin
               checkCnt++;
               assert (stall === 1'b0) else begin
                  $display("FAILED at %0t: stall high in done cycle of %h", $time, pend.addr);
                  valueErrs++;
               end
               assert (cacheHit === pend.exp.hit) else begin
                  $display("FAILED at %0t: %h cacheHit %b, expected %b", $time, pend.addr,
                           cacheHit, pend.exp.hit);
                  valueErrs++;
               end
               if (pend.isRead) begin
                  assert (dataOut === pend.exp.data) else begin
                     $display("FAILED at %0t: read %h gave %h, expected %h", $time, pend.addr,
                              dataOut, pend.exp.data);
                     valueErrs++;
                  end
               end
               // a hit is done two cycles after the strobe cycle
               if (pend.exp.hit) begin
                  assert (cycleCnt == pend.acceptCycle + 2) else begin
                     $display("FAILED at %0t: hit on %h took %0d cycles", $time, pend.addr,
                              cycleCnt - pend.acceptCycle);
                     valueErrs++;
                  end
               end
               void'(pendQ.pop_front());
            end
         end
      end
   end

   // ##########################################################
   // stimulus
   // ##########################################################
   initial begin : runTest
      int waitCnt;
      int i;
      logic [addrWidth-1:0] a;
      logic isWrite;
      clk = 1'b0;
      rst = 1'b1;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      dataIn = '0;
      seed = $urandom(32'he7d1_2644);
      repeat (resetCycles) @(posedge clk);
      #driveDelay;
      rst = 1'b0;
      assert (stall === 1'b0 && done === 1'b0 && cacheHit === 1'b0) else begin
         $display("FAILED at %0t: handshake not idle after reset", $time);
         valueErrs++;
      end
      // write miss and then a read hit with fixed latency
      issueAccess(1'b1, makeAddr(3, 8'h10, 1), 16'ha5a5);
      issueAccess(1'b0, makeAddr(3, 8'h10, 1), 16'h0000);
      idleCycles(2);
      // write miss whose reread hits
      issueAccess(1'b1, makeAddr(7, 8'h22, 2), 16'h1234);
      issueAccess(1'b0, makeAddr(7, 8'h22, 2), 16'h0000);
      idleCycles(3);
      // three tags on one set where the third pushes out a dirty line
      issueAccess(1'b1, makeAddr(1, 8'h35, 0), 16'hbeef);
      issueAccess(1'b0, makeAddr(1, 8'h35, 0), 16'h0000);
      issueAccess(1'b1, makeAddr(2, 8'h35, 0), 16'hcafe);
      issueAccess(1'b0, makeAddr(2, 8'h35, 0), 16'h0000);
      issueAccess(1'b1, makeAddr(9, 8'h35, 0), 16'hf00d);
      issueAccess(1'b0, makeAddr(9, 8'h35, 0), 16'h0000);
      issueAccess(1'b0, makeAddr(1, 8'h35, 0), 16'h0000);
      issueAccess(1'b0, makeAddr(2, 8'h35, 0), 16'h0000);
      // back to back strobes that land in the previous done cycle
      issueAccess(1'b1, makeAddr(9, 8'h35, 3), 16'h5a5a);
      issueAccess(1'b0, makeAddr(9, 8'h35, 3), 16'h0000);
      // random mix over two sets with four tags and four words
      for (i = 0; i < randomOps && !abortRun; i++) begin
         a = makeAddr(1 + $urandom % 4, 8'h40 + $urandom % 2, $urandom % 4);
         // never read a word that was not written
         isWrite = ($urandom % 2 == 0) || !refMem.exists(a[addrWidth-1:1]);
         issueAccess(isWrite, a, 16'($urandom));
         if ($urandom % 4 == 0) begin
            idleCycles(1 + $urandom % 3);
         end
      end
      waitCnt = 0;
      while (pendQ.size() != 0 && !abortRun && waitCnt < doneLimit) begin
         @(posedge clk);
         #driveDelay;
         waitCnt++;
      end
      if (pendQ.size() != 0 && !abortRun) begin
         $display("timeout: requests still pending at the end of the run");
         otherErrs++;
      end
      assert (doneStrobes > 0) else begin
         $display("no request was accepted in a done cycle");
         otherErrs++;
      end
      $display("checked %0d accesses, value errors %0d, other errors %0d", checkCnt,
               valueErrs, otherErrs);
      if (valueErrs == 0 && otherErrs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
memSysPkg.sv
cacheWay.sv
waySelect.sv
bankedMemory.sv
cacheController.sv
memSystem.sv
memSystemTb.sv

//--- waySelect.sv
`timescale 1ns/1ps
`default_nettype none

module waySelect
   import memSysPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  wayStatusT            way0,
   input  wayStatusT            way1,
   input  logic                 wayWrite,
   input  logic                 lockWay,
   input  logic                 accessDone,
   output logic                 write0,
   output logic                 write1,
   output logic                 anyHit,
   output logic                 targetDirty,
   output logic                 targetValid,
   output logic [tagBits-1:0]   targetTag,
   output logic [wordWidth-1:0] dataOut
);

   logic replBit;
   logic lockedWay;
   logic freshWay;
   logic targetWay;
   logic writeWay;
   wayStatusT target;

   // prefer an empty way, else the replacement bit picks
   always_comb begin
      if (!way0.valid) begin
         freshWay = 1'b0;
      end else if (!way1.valid) begin
         freshWay = 1'b1;
      end else begin
         freshWay = replBit;
      end
   end

   // live choice while locking, held choice after that
   assign targetWay = lockWay ? freshWay : lockedWay;
   assign target = targetWay ? way1 : way0;

   assign anyHit = way0.hit | way1.hit;
   assign targetDirty = target.dirty;
   assign targetValid = target.valid;
   assign targetTag = target.tag;

   // hit way takes the write, otherwise the miss target
   assign writeWay = anyHit ? way1.hit : targetWay;
   assign write0 = wayWrite & ~writeWay;
   assign write1 = wayWrite & writeWay;

   // eviction reads the target line word by word
   assign dataOut = anyHit ? (way1.hit ? way1.data : way0.data) : target.data;

   always_ff @(posedge clk) begin
      if (rst) begin
         replBit <= 1'b0;
         lockedWay <= 1'b0;
      end else begin
         if (accessDone) begin
            replBit <= ~replBit;
         end
         if (lockWay) begin
            lockedWay <= freshWay;
         end
      end
   end

   // a line lives in at most one way
   singleHit: assert property (
      @(posedge clk) disable iff (rst)
      !(way0.hit && way1.hit)
   ) else $error("both ways hit");

endmodule

`default_nettype wire
